// File: rtl/key_cmd_slot.sv
// Batch command slot
// One-entry valid/ready register, refillable in the cycle it is popped
`timescale 1ns/1ns

module key_cmd_slot (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  key_mgr_pkg::batch_cmd_t in_cmd_i,
  input  logic                    in_vld_i,
  output logic                    in_rdy_o,
  output key_mgr_pkg::batch_cmd_t out_cmd_o,
  output logic                    out_vld_o,
  input  logic                    out_pop_i
);

  key_mgr_pkg::batch_cmd_t cmd_q;
  logic                    vld_q;

  // Room when empty, or when the held command leaves this cycle
  assign in_rdy_o = ~vld_q | out_pop_i;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      vld_q <= 1'b0;
    end else if (in_vld_i && in_rdy_o) begin
      vld_q <= 1'b1;
    end else if (out_pop_i) begin
      vld_q <= 1'b0;
    end
    // Payload
    if (in_vld_i && in_rdy_o) cmd_q <= in_cmd_i;
  end

  assign out_cmd_o = cmd_q;
  assign out_vld_o = vld_q;

endmodule

// File: rtl/key_mgr_cut.sv
// Key delivery unit, one cut
// Wishbone key load, batch command slot, shared read control and the
// systolic chain of column nodes
`timescale 1ns/1ns

module key_mgr_cut #(
  parameter  int RAM_LATENCY = 2,
  localparam int BUF_DEPTH   = RAM_LATENCY + 3
) (
  input  logic                                                   clk,
  input  logic                                                   s_rst_n,
  // Wishbone key load
  input  logic                                                   wb_cyc_i,
  input  logic                                                   wb_stb_i,
  input  logic                                                   wb_we_i,
  input  logic [key_mgr_pkg::G_IDX_W+key_mgr_pkg::RAM_ADD_W-1:0] wb_adr_i,
  input  logic [key_mgr_pkg::FCOEF_NB*key_mgr_pkg::OP_W-1:0]     wb_dat_i,
  output logic                                                   wb_ack_o,
  output logic [key_mgr_pkg::FCOEF_NB*key_mgr_pkg::OP_W-1:0]     wb_dat_o,
  // Batch commands
  input  key_mgr_pkg::batch_cmd_t                                cmd_i,
  input  logic                                                   cmd_vld_i,
  output logic                                                   cmd_rdy_o,
  // Key stream, indexed by coefficient then column
  output logic [key_mgr_pkg::FCOEF_NB-1:0][key_mgr_pkg::GLWE_K_P1-1:0][key_mgr_pkg::OP_W-1:0]
                                                                 key_o,
  output logic [key_mgr_pkg::GLWE_K_P1-1:0]                      key_vld_o,
  input  logic [key_mgr_pkg::GLWE_K_P1-1:0]                      key_rdy_i
);

  key_mgr_pkg::wr_beat_t  beat_chain [key_mgr_pkg::GLWE_K_P1+1];
  key_mgr_pkg::node_cmd_t cmd_chain [key_mgr_pkg::GLWE_K_P1+1];
  key_mgr_pkg::batch_cmd_t slot_cmd;
  logic                    slot_vld;
  logic                    slot_pop;
  logic [key_mgr_pkg::GLWE_K_P1-1:0][key_mgr_pkg::FCOEF_NB-1:0][key_mgr_pkg::OP_W-1:0]
                           node_key;
  logic [key_mgr_pkg::GLWE_K_P1-1:0][BUF_DEPTH-1:0] node_buf_en;

  key_wb_wr u_wb_wr (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_o (wb_ack_o),
    .wb_dat_o (wb_dat_o),
    .beat_o   (beat_chain[0])
  );

  key_cmd_slot u_cmd_slot (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .in_cmd_i  (cmd_i),
    .in_vld_i  (cmd_vld_i),
    .in_rdy_o  (cmd_rdy_o),
    .out_cmd_o (slot_cmd),
    .out_vld_o (slot_vld),
    .out_pop_i (slot_pop)
  );

  // Credit comes from node 0, the other nodes follow it in lockstep
  key_rd_ctrl #(
    .RAM_LATENCY (RAM_LATENCY)
  ) u_rd_ctrl (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .cmd_i      (slot_cmd),
    .cmd_vld_i  (slot_vld),
    .buf_en_i   (node_buf_en[0]),
    .cmd_pop_o  (slot_pop),
    .node_cmd_o (cmd_chain[0])
  );

  // --------------------------------------------------------------------------
  // Node chain, node g runs g cycles behind node 0
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < key_mgr_pkg::GLWE_K_P1; g++) begin : gen_node
    key_node #(
      .RAM_LATENCY (RAM_LATENCY),
      .G_ID        (g)
    ) u_node (
      .clk         (clk),
      .s_rst_n     (s_rst_n),
      .prev_cmd_i  (cmd_chain[g]),
      .prev_beat_i (beat_chain[g]),
      .key_rdy_i   (key_rdy_i[g]),
      .next_cmd_o  (cmd_chain[g+1]),
      .next_beat_o (beat_chain[g+1]),
      .key_o       (node_key[g]),
      .key_vld_o   (key_vld_o[g]),
      .buf_en_o    (node_buf_en[g])
    );
    // Column-major node data to coefficient-major output
    for (genvar c = 0; c < key_mgr_pkg::FCOEF_NB; c++) begin : gen_coef
      assign key_o[c][g] = node_key[g][c];
    end
  end

endmodule

// File: rtl/key_mgr_pkg.sv
// Key delivery unit shared definitions
// Cut sizes plus the batch command, node command and key write beat types
package key_mgr_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int OP_W        = 16;
  localparam int GLWE_K_P1   = 2;
  localparam int FCOEF_NB    = 2;
  localparam int RAM_ADD_W   = 6;
  localparam int G_IDX_W     = 1;
  localparam int STG_ITER_NB = 4;
  localparam int INTL_L      = 2;
  localparam int PBS_NB_W    = 3;

  // Batch command, one key pass per bootstrap
  typedef struct packed {
    logic [PBS_NB_W-1:0]  pbs_nb;
    logic [RAM_ADD_W-1:0] add_ofs;
  } batch_cmd_t;

  // Read command travelling down the node chain
  typedef struct packed {
    logic                 buf_in_avail;
    logic                 rd_en;
    logic [RAM_ADD_W-1:0] rd_add;
  } node_cmd_t;

  // Key write beat, coefficient 0 in the low bits of data
  typedef struct packed {
    logic                          en;
    logic [RAM_ADD_W-1:0]          add;
    logic [G_IDX_W-1:0]            g_idx;
    logic [FCOEF_NB-1:0][OP_W-1:0] data;
  } wr_beat_t;

endpackage

// File: rtl/key_node.sv
// Key node for one GLWE column
// Key RAM, read latency pipe and shift output buffer, with the read
// command and write beat forwarded one cycle later to the next node
`timescale 1ns/1ns

module key_node #(
  parameter  int RAM_LATENCY = 2,
  parameter  int G_ID        = 0,
  localparam int BUF_DEPTH   = RAM_LATENCY + 3
) (
  input  logic                                                  clk,
  input  logic                                                  s_rst_n,
  input  key_mgr_pkg::node_cmd_t                                prev_cmd_i,
  input  key_mgr_pkg::wr_beat_t                                 prev_beat_i,
  input  logic                                                  key_rdy_i,
  output key_mgr_pkg::node_cmd_t                                next_cmd_o,
  output key_mgr_pkg::wr_beat_t                                 next_beat_o,
  output logic [key_mgr_pkg::FCOEF_NB-1:0][key_mgr_pkg::OP_W-1:0] key_o,
  output logic                                                  key_vld_o,
  output logic [BUF_DEPTH-1:0]                                  buf_en_o
);

  typedef logic [key_mgr_pkg::FCOEF_NB-1:0][key_mgr_pkg::OP_W-1:0] word_t;

  key_mgr_pkg::node_cmd_t cmd_q;
  key_mgr_pkg::wr_beat_t  beat_q;
  logic                   wr_hit;
  word_t                  ram [2**key_mgr_pkg::RAM_ADD_W];
  word_t                  rd_pipe [RAM_LATENCY];
  word_t                  buf_data [BUF_DEPTH];
  word_t                  buf_data_nxt [BUF_DEPTH];
  logic [BUF_DEPTH-1:0]   buf_en;
  logic [BUF_DEPTH-1:0]   buf_en_nxt;
  logic                   buf_pop;

  // --------------------------------------------------------------------------
  // Systolic stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cmd_q.rd_en        <= 1'b0;
      cmd_q.buf_in_avail <= 1'b0;
      beat_q.en          <= 1'b0;
    end else begin
      cmd_q.rd_en        <= prev_cmd_i.rd_en;
      cmd_q.buf_in_avail <= prev_cmd_i.buf_in_avail;
      beat_q.en          <= prev_beat_i.en;
    end
    cmd_q.rd_add <= prev_cmd_i.rd_add;
    beat_q.add   <= prev_beat_i.add;
    beat_q.g_idx <= prev_beat_i.g_idx;
    beat_q.data  <= prev_beat_i.data;
  end

  assign next_cmd_o  = cmd_q;
  assign next_beat_o = beat_q;

  // --------------------------------------------------------------------------
  // Key RAM
  // --------------------------------------------------------------------------
  // Only beats addressed to this column are kept
  assign wr_hit = beat_q.en & (beat_q.g_idx == key_mgr_pkg::G_IDX_W'(G_ID));

  always_ff @(posedge clk) begin
    if (wr_hit) ram[beat_q.add] <= beat_q.data;
  end

  // Read data leaves the last stage RAM_LATENCY cycles after rd_en
  always_ff @(posedge clk) begin
    if (cmd_q.rd_en) rd_pipe[0] <= ram[cmd_q.rd_add];
    for (int i = 1; i < RAM_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // --------------------------------------------------------------------------
  // Output buffer
  // --------------------------------------------------------------------------
  // Head at place 0, occupied places always contiguous from the head
  assign buf_pop = buf_en[0] & key_rdy_i;

  always_comb begin
    logic [BUF_DEPTH-1:0] en_s;
    logic [BUF_DEPTH-1:0] ins;
    word_t                data_s [BUF_DEPTH];
    // Shift on pop
    en_s = buf_pop ? (buf_en >> 1) : buf_en;
    for (int i = 0; i < BUF_DEPTH - 1; i++) begin
      data_s[i] = buf_pop ? buf_data[i+1] : buf_data[i];
    end
    data_s[BUF_DEPTH-1] = buf_data[BUF_DEPTH-1];
    // First free place after the shift
    ins        = {en_s[BUF_DEPTH-2:0], 1'b1} & ~en_s;
    buf_en_nxt = en_s;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      buf_data_nxt[i] = data_s[i];
      if (cmd_q.buf_in_avail && ins[i]) begin
        buf_en_nxt[i]   = 1'b1;
        buf_data_nxt[i] = rd_pipe[RAM_LATENCY-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      buf_en <= '0;
    end else begin
      buf_en <= buf_en_nxt;
    end
  end

  always_ff @(posedge clk) begin
    buf_data <= buf_data_nxt;
  end

  assign key_o     = buf_data[0];
  assign key_vld_o = buf_en[0];
  assign buf_en_o  = buf_en;

endmodule

// File: rtl/key_rd_ctrl.sv
// Key read control shared by all lanes of the cut
// Walks interleave, stage iteration and bootstrap counters, and issues
// node read commands while node 0 has buffer credit left
`timescale 1ns/1ns

module key_rd_ctrl #(
  parameter  int RAM_LATENCY = 2,
  localparam int BUF_DEPTH   = RAM_LATENCY + 3
) (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  key_mgr_pkg::batch_cmd_t cmd_i,
  input  logic                    cmd_vld_i,
  input  logic [BUF_DEPTH-1:0]    buf_en_i,
  output logic                    cmd_pop_o,
  output key_mgr_pkg::node_cmd_t  node_cmd_o
);

  // Command register in node 0 adds one cycle to the RAM latency
  localparam int INFLIGHT_NB = RAM_LATENCY + 1;
  localparam int CNT_W       = $clog2(INFLIGHT_NB + BUF_DEPTH + 1);
  localparam int INTL_W      = $clog2(key_mgr_pkg::INTL_L);
  localparam int STG_W       = $clog2(key_mgr_pkg::STG_ITER_NB);

  logic [INTL_W-1:0]                intl_idx;
  logic [STG_W-1:0]                 stg_iter;
  logic [key_mgr_pkg::PBS_NB_W-1:0] pbs_id;
  logic [key_mgr_pkg::RAM_ADD_W-1:0] rp;
  logic                             last_intl;
  logic                             last_stg;
  logic                             last_pbs;
  logic                             last_pass_word;
  logic                             do_read;
  logic [INFLIGHT_NB-1:0]           inflight;
  logic [CNT_W-1:0]                 credit_cnt;

  // --------------------------------------------------------------------------
  // Counters and read pointer
  // --------------------------------------------------------------------------
  assign last_intl      = (intl_idx == INTL_W'(key_mgr_pkg::INTL_L - 1));
  assign last_stg       = (stg_iter == STG_W'(key_mgr_pkg::STG_ITER_NB - 1));
  assign last_pbs       = (pbs_id == key_mgr_pkg::PBS_NB_W'(cmd_i.pbs_nb - 1'b1));
  // Last word of one key pass
  assign last_pass_word = last_intl & last_stg;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      intl_idx <= '0;
      stg_iter <= '0;
      pbs_id   <= '0;
      rp       <= '0;
    end else if (do_read) begin
      intl_idx <= last_intl ? '0 : intl_idx + 1'b1;
      if (last_intl) stg_iter <= last_stg ? '0 : stg_iter + 1'b1;
      if (last_pass_word) pbs_id <= last_pbs ? '0 : pbs_id + 1'b1;
      // Pointer restarts for every bootstrap of the batch
      rp <= last_pass_word ? '0 : rp + 1'b1;
    end
  end

  // Slot is freed by the final read of the batch
  assign cmd_pop_o = do_read & last_pass_word & last_pbs;

  // --------------------------------------------------------------------------
  // Credit
  // --------------------------------------------------------------------------
  // Bit i set means a read issued i+1 cycles ago, still on its way
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      inflight <= '0;
    end else begin
      inflight <= {inflight[INFLIGHT_NB-2:0], do_read};
    end
  end

  // Reads in flight plus words held in node 0
  assign credit_cnt = CNT_W'($countones(inflight)) + CNT_W'($countones(buf_en_i));
  assign do_read    = cmd_vld_i & (credit_cnt < CNT_W'(BUF_DEPTH));

  // --------------------------------------------------------------------------
  // Node command
  // --------------------------------------------------------------------------
  // Landing mark one cycle early, node 0 registers it
  assign node_cmd_o.buf_in_avail = inflight[RAM_LATENCY-1];
  assign node_cmd_o.rd_en        = do_read;
  assign node_cmd_o.rd_add       = rp + cmd_i.add_ofs;

endmodule

// File: rtl/key_wb_wr.sv
// Wishbone classic write slave for the key RAMs
// Acks each request one cycle later and emits one write beat per write
`timescale 1ns/1ns

module key_wb_wr (
  input  logic                                           clk,
  input  logic                                           s_rst_n,
  input  logic                                           wb_cyc_i,
  input  logic                                           wb_stb_i,
  input  logic                                           wb_we_i,
  input  logic [key_mgr_pkg::G_IDX_W+key_mgr_pkg::RAM_ADD_W-1:0] wb_adr_i,
  input  logic [key_mgr_pkg::FCOEF_NB*key_mgr_pkg::OP_W-1:0]     wb_dat_i,
  output logic                                           wb_ack_o,
  output logic [key_mgr_pkg::FCOEF_NB*key_mgr_pkg::OP_W-1:0]     wb_dat_o,
  output key_mgr_pkg::wr_beat_t                          beat_o
);

  logic                  ack_q;
  logic                  req;
  key_mgr_pkg::wr_beat_t beat_q;

  // New request only, the ack cycle itself is not a new one
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ack_q     <= 1'b0;
      beat_q.en <= 1'b0;
    end else begin
      ack_q     <= req;
      beat_q.en <= req & wb_we_i;
    end
    // Address split, column index above the RAM address
    beat_q.add   <= wb_adr_i[key_mgr_pkg::RAM_ADD_W-1:0];
    beat_q.g_idx <= wb_adr_i[key_mgr_pkg::RAM_ADD_W +: key_mgr_pkg::G_IDX_W];
    beat_q.data  <= wb_dat_i;
  end

  assign wb_ack_o = ack_q;
  // No read path on the key RAMs
  assign wb_dat_o = '0;
  assign beat_o   = beat_q;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the key delivery unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_key_mgr \
  --Mdir obj_dir -o sim_key_mgr
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_key_mgr)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// File: src.f
rtl/key_mgr_pkg.sv
rtl/key_cmd_slot.sv
rtl/key_wb_wr.sv
rtl/key_rd_ctrl.sv
rtl/key_node.sv
rtl/key_mgr_cut.sv
testbench/tb_clk_gen.sv
testbench/tb_checker.sv
testbench/tb_key_mgr.sv

// File: testbench/tb_checker.sv
// Key delivery unit checker
// Predicts the key stream of every column from the accepted batch commands,
// compares each popped word and watches Wishbone ack and column timing
`timescale 1ns/1ns

module tb_checker #(
  parameter int KEY_BASE = 0
) (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic                    wb_ack_i,
  input  logic [key_mgr_pkg::FCOEF_NB*key_mgr_pkg::OP_W-1:0] wb_rdat_i,
  input  key_mgr_pkg::batch_cmd_t cmd_i,
  input  logic                    cmd_vld_i,
  input  logic                    cmd_rdy_i,
  input  logic [key_mgr_pkg::FCOEF_NB-1:0][key_mgr_pkg::GLWE_K_P1-1:0][key_mgr_pkg::OP_W-1:0]
                                  key_i,
  input  logic [key_mgr_pkg::GLWE_K_P1-1:0] key_vld_i,
  input  logic [key_mgr_pkg::GLWE_K_P1-1:0] key_rdy_i,
  input  logic                    final_i,
  output int                      val_err_o,
  output int                      oth_err_o,
  output int                      word_cnt_o,
  output int                      pending_o
);

  localparam int COL_NB     = key_mgr_pkg::GLWE_K_P1;
  localparam int FC         = key_mgr_pkg::FCOEF_NB;
  localparam int OP_W       = key_mgr_pkg::OP_W;
  localparam int RAM_DEPTH  = 2**key_mgr_pkg::RAM_ADD_W;
  localparam int PASS_WORDS = key_mgr_pkg::STG_ITER_NB * key_mgr_pkg::INTL_L;

  // Expected RAM addresses, one queue per column
  int                exp_add [COL_NB][$];
  int                val_err    = 0;
  int                oth_err    = 0;
  int                word_cnt   = 0;
  int                pend       = 0;
  logic              ack_exp    = 1'b0;
  logic              ack_we     = 1'b0;
  logic              final_done = 1'b0;
  logic [COL_NB-1:0] vld0_hist  = '0;

  // Key content rule, column g address a coefficient c
  function automatic logic [OP_W-1:0] key_value(input int g, input int a, input int c);
    return OP_W'(a * 16 + g * 4 + c + KEY_BASE);
  endfunction

  // --------------------------------------------------------------------------
  // Sampling at the falling edge, all inputs and outputs are settled there
  // --------------------------------------------------------------------------
  always @(negedge clk) begin : sample
    int               a;
    logic [OP_W-1:0]  exp_w;
    if (!s_rst_n) begin
      // Idle outputs while in reset
      if (wb_ack_i !== 1'b0) begin
        $display("ERR t=%0t wb_ack_o exp 0 got %b", $time, wb_ack_i);
        val_err++;
      end
      if (key_vld_i !== '0) begin
        $display("ERR t=%0t key_vld_o exp 0 got %b", $time, key_vld_i);
        val_err++;
      end
      if (cmd_rdy_i !== 1'b1) begin
        $display("ERR t=%0t cmd_rdy_o exp 1 got %b", $time, cmd_rdy_i);
        val_err++;
      end
      ack_exp   = 1'b0;
      ack_we    = 1'b0;
      vld0_hist = '0;
    end else begin
      // Ack due exactly one cycle after a new request
      if (wb_ack_i !== ack_exp) begin
        $display("ERR t=%0t wb_ack_o exp %b got %b", $time, ack_exp, wb_ack_i);
        val_err++;
      end
      // Read acks carry zero data
      if (wb_ack_i === 1'b1 && !ack_we && wb_rdat_i !== '0) begin
        $display("ERR t=%0t wb_dat_o exp 0 got %h", $time, wb_rdat_i);
        val_err++;
      end
      ack_exp = wb_cyc_i & wb_stb_i & ~wb_ack_i;
      ack_we  = wb_we_i;
      // Column g follows column 0 by g cycles
      for (int g = 1; g < COL_NB; g++) begin
        if (key_vld_i[g] !== vld0_hist[g-1]) begin
          $display("ERR t=%0t key_vld_o[%0d] exp %b got %b", $time, g, vld0_hist[g-1],
                   key_vld_i[g]);
          val_err++;
        end
      end
      vld0_hist = {vld0_hist[COL_NB-2:0], key_vld_i[0]};
      // Popped words
      for (int g = 0; g < COL_NB; g++) begin
        if (key_vld_i[g] === 1'b1 && key_rdy_i[g] === 1'b1) begin
          if (exp_add[g].size() == 0) begin
            $display("Column %0d delivered a word that no command asked for at %0t", g, $time);
            oth_err++;
          end else begin
            a = exp_add[g].pop_front();
            word_cnt++;
            for (int c = 0; c < FC; c++) begin
              exp_w = key_value(g, a, c);
              if (key_i[c][g] !== exp_w) begin
                $display("ERR t=%0t key_o[%0d][%0d] exp %h got %h", $time, c, g, exp_w,
                         key_i[c][g]);
                val_err++;
              end
            end
          end
        end
      end
      // Accepted command, n passes over offset .. offset+7
      if (cmd_vld_i === 1'b1 && cmd_rdy_i === 1'b1) begin
        for (int g = 0; g < COL_NB; g++) begin
          for (int p = 0; p < int'(cmd_i.pbs_nb); p++) begin
            for (int i = 0; i < PASS_WORDS; i++) begin
              exp_add[g].push_back((int'(cmd_i.add_ofs) + i) % RAM_DEPTH);
            end
          end
        end
      end
      // Words still owed once the run is over
      if (final_i === 1'b1 && !final_done) begin
        final_done = 1'b1;
        for (int g = 0; g < COL_NB; g++) begin
          if (exp_add[g].size() != 0) begin
            $display("Column %0d never delivered %0d expected words", g, exp_add[g].size());
            oth_err++;
          end
        end
      end
    end
    pend = 0;
    for (int g = 0; g < COL_NB; g++) begin
      pend += exp_add[g].size();
    end
  end

  assign val_err_o  = val_err;
  assign oth_err_o  = oth_err;
  assign word_cnt_o = word_cnt;
  assign pending_o  = pend;

endmodule

// File: testbench/tb_clk_gen.sv
// Testbench clock and reset
// 20 ns clock, synchronous reset held low over the first 2 rising edges
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD  = 20,
  parameter int RST_CYC = 2
) (
  output logic clk_o,
  output logic s_rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release a little after the edge, like every other input
  initial begin
    s_rst_n_o = 1'b0;
    repeat (RST_CYC) @(posedge clk_o);
    #2;
    s_rst_n_o = 1'b1;
  end

endmodule

// File: testbench/tb_key_mgr.sv
// Testbench for the key delivery unit
// Loads every key word over Wishbone, then runs a table of batch commands
// with steady or LCG driven back-pressure on the key stream
`timescale 1ns/1ns

module tb_key_mgr;

  localparam int RAM_LATENCY = 2;
  localparam int COL_NB      = key_mgr_pkg::GLWE_K_P1;
  localparam int FC          = key_mgr_pkg::FCOEF_NB;
  localparam int OP_W        = key_mgr_pkg::OP_W;
  localparam int ADR_W       = key_mgr_pkg::G_IDX_W + key_mgr_pkg::RAM_ADD_W;
  localparam int RAM_DEPTH   = 2**key_mgr_pkg::RAM_ADD_W;
  localparam int PASS_WORDS  = key_mgr_pkg::STG_ITER_NB * key_mgr_pkg::INTL_L;
  localparam int KEY_BASE    = 'h5000;
  localparam int DRAIN_CYC   = 20;
  localparam int STALL_CYC   = 100;
  localparam int ROW_NB      = 7;

  // One table row, offset, pass count and random ready
  typedef struct packed {
    logic [key_mgr_pkg::RAM_ADD_W-1:0] ofs;
    logic [key_mgr_pkg::PBS_NB_W-1:0]  cnt;
    logic                              rnd;
  } stim_row_t;

  // Plain pass, repeat with offset, then back-pressure and address wrap
  localparam stim_row_t STIM [ROW_NB] = '{
    '{6'd0,  3'd1, 1'b0},
    '{6'd13, 3'd3, 1'b0},
    '{6'd40, 3'd2, 1'b1},
    '{6'd5,  3'd1, 1'b1},
    '{6'd58, 3'd2, 1'b1},
    '{6'd21, 3'd4, 1'b0},
    '{6'd33, 3'd1, 1'b1}
  };

  logic                    clk;
  logic                    s_rst_n;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  logic [ADR_W-1:0]        wb_adr_i;
  logic [FC*OP_W-1:0]      wb_dat_i;
  logic                    wb_ack_o;
  logic [FC*OP_W-1:0]      wb_dat_o;
  key_mgr_pkg::batch_cmd_t cmd_i;
  logic                    cmd_vld_i;
  logic                    cmd_rdy_o;
  logic [FC-1:0][COL_NB-1:0][OP_W-1:0] key_o;
  logic [COL_NB-1:0]       key_vld_o;
  logic [COL_NB-1:0]       key_rdy_i = '0;
  logic                    rnd_mode  = 1'b0;
  logic                    new_rdy;
  logic [31:0]             lcg_state = 32'h73dd;
  logic                    final_chk;
  int                      val_err;
  int                      oth_err;
  int                      word_cnt;
  int                      pending;
  int                      cycle_cnt = 0;
  int                      limit_cyc;

  tb_clk_gen #(.PERIOD(20), .RST_CYC(2)) u_clk_gen (
    .clk_o     (clk),
    .s_rst_n_o (s_rst_n)
  );

  key_mgr_cut #(.RAM_LATENCY(RAM_LATENCY)) DUT (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .cmd_i     (cmd_i),
    .cmd_vld_i (cmd_vld_i),
    .cmd_rdy_o (cmd_rdy_o),
    .key_o     (key_o),
    .key_vld_o (key_vld_o),
    .key_rdy_i (key_rdy_i)
  );

  tb_checker #(.KEY_BASE(KEY_BASE)) u_checker (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_ack_i   (wb_ack_o),
    .wb_rdat_i  (wb_dat_o),
    .cmd_i      (cmd_i),
    .cmd_vld_i  (cmd_vld_i),
    .cmd_rdy_i  (cmd_rdy_o),
    .key_i      (key_o),
    .key_vld_i  (key_vld_o),
    .key_rdy_i  (key_rdy_i),
    .final_i    (final_chk),
    .val_err_o  (val_err),
    .oth_err_o  (oth_err),
    .word_cnt_o (word_cnt),
    .pending_o  (pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Key content rule, column g address a coefficient c
  function automatic logic [OP_W-1:0] key_value(input int g, input int a, input int c);
    return OP_W'(a * 16 + g * 4 + c + KEY_BASE);
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------
  // One classic write, held until ack, then one idle cycle
  task automatic wb_write(input int g, input int a);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = ADR_W'(g * RAM_DEPTH + a);
    for (int c = 0; c < FC; c++) begin
      wb_dat_i[c*OP_W +: OP_W] = key_value(g, a, c);
    end
    do begin
      @(posedge clk);
      #2;
    end while (wb_ack_o !== 1'b1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(posedge clk);
    #2;
  endtask

  // One classic read, no key data comes back
  task automatic wb_read(input int g, input int a);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = ADR_W'(g * RAM_DEPTH + a);
    do begin
      @(posedge clk);
      #2;
    end while (wb_ack_o !== 1'b1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(posedge clk);
    #2;
  endtask

  // Hold the command until the slot takes it
  task automatic send_cmd(input stim_row_t row);
    logic taken;
    cmd_i.pbs_nb  = row.cnt;
    cmd_i.add_ofs = row.ofs;
    cmd_vld_i     = 1'b1;
    rnd_mode      = row.rnd;
    do begin
      @(negedge clk);
      taken = cmd_rdy_o;
      @(posedge clk);
      #2;
    end while (!taken);
    cmd_vld_i = 1'b0;
  endtask

  // Column 0 ready from the LCG or high, column g is column 0 g cycles late
  always @(posedge clk) begin
    #2;
    lcg_state = lcg_next(lcg_state);
    new_rdy   = rnd_mode ? lcg_state[31] : 1'b1;
    key_rdy_i = {key_rdy_i[COL_NB-2:0], new_rdy};
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit_cyc) begin
      $display("Timeout, the run did not finish within %0d cycles", limit_cyc);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int words;
    int stall;
    int last_cnt;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    cmd_i     = '0;
    cmd_vld_i = 1'b0;
    final_chk = 1'b0;
    // Loaded words plus streamed words over all columns
    words = COL_NB * RAM_DEPTH;
    for (int r = 0; r < ROW_NB; r++) begin
      words += COL_NB * int'(STIM[r].cnt) * PASS_WORDS;
    end
    limit_cyc = words * 4 + 500;

    wait (s_rst_n === 1'b1);
    @(posedge clk);
    #2;
    for (int g = 0; g < COL_NB; g++) begin
      for (int a = 0; a < RAM_DEPTH; a++) begin
        wb_write(g, a);
      end
    end
    // Reads must leave streamed words untouched
    wb_read(0, 0);
    wb_read(1, 13);

    for (int r = 0; r < ROW_NB; r++) begin
      send_cmd(STIM[r]);
    end

    // Until every word arrived, or the stream stopped moving
    stall    = 0;
    last_cnt = word_cnt;
    while (pending != 0 && stall < STALL_CYC) begin
      @(posedge clk);
      #2;
      stall    = (word_cnt == last_cnt) ? stall + 1 : 0;
      last_cnt = word_cnt;
    end
    // Margin for any extra word
    repeat (DRAIN_CYC) @(posedge clk);
    #2;
    final_chk = 1'b1;
    @(posedge clk);
    #2;
    $display("Words checked %0d, value errors %0d, other errors %0d", word_cnt, val_err,
             oth_err);
    if (val_err == 0 && oth_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
